// ==== all.f ====
+incdir+hw
hw/fmap_pkg.sv
hw/dual_port_ram.sv
hw/fmap_buffer_array.sv
hw/psum_accumulate_stage.sv
hw/pair_pool_stage.sv
hw/layer_pipeline_top.sv
tests/tb_layer_pipeline.sv

// ==== run.sh ====
#!/bin/sh
# compile with Verilator, run, and decide the result from the log
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f all.f --top-module tb_layer_pipeline -o tb_sim \
	&& ./obj_dir/tb_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Finished with no errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== tests/tb_layer_pipeline.sv ====
`include "fmap_consts.svh"

module tb_layer_pipeline;

	import fmap_pkg::*;

	localparam int NUM_PIXELS = `FMAP_SIZE*`FMAP_SIZE;
	localparam int NUM_PAIRS  = NUM_PIXELS/2;
	localparam int NUM_ROUNDS = 6;
	localparam int MAX_PASSES = 3;
	// worst pass has a gap after every beat
	localparam int PASS_CYCLES    = 2*NUM_PIXELS + 8;
	localparam int ROUND_CYCLES   = MAX_PASSES*PASS_CYCLES + 16;
	localparam int TIMEOUT_CYCLES = (NUM_ROUNDS + 2)*ROUND_CYCLES + 16;

	logic       clk;
	logic       reset;
	logic       swap;
	logic       acc_valid;
	logic       acc_first;
	fmap_addr_t acc_address;
	fmap_word_t acc_data [`NUM_UNITS];
	logic       pool_start;
	logic       pool_valid;
	logic       pool_done;
	logic       pool_busy;
	fmap_word_t pool_data [`NUM_UNITS];

	// reference model of the three bank groups
	fmap_word_t model_mem [`NUM_GROUPS][`NUM_UNITS][NUM_PIXELS];
	int         model_sel;

	layer_pipeline_top i_layer_pipeline_top (
		.clk         (clk),
		.reset       (reset),
		.swap        (swap),
		.acc_valid   (acc_valid),
		.acc_first   (acc_first),
		.acc_address (acc_address),
		.acc_data    (acc_data),
		.pool_start  (pool_start),
		.pool_valid  (pool_valid),
		.pool_done   (pool_done),
		.pool_busy   (pool_busy),
		.pool_data   (pool_data)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial
	begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		$display("watchdog expired after %0d cycles, the test is stuck", TIMEOUT_CYCLES);
		$display("Finished with errors");
		$fatal(1, "timeout");
	end

	// ************************************************************
	// checks
	// ************************************************************

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("Finished with errors");
		$fatal(1, "test stopped");
	endtask

	task automatic check_value(input string name, input logic signed [31:0] expected,
		input logic signed [31:0] actual);
		if (actual !== expected)
		begin
			$display("[ERROR] t=%0t %s expected %0d got %0d", $time, name, expected, actual);
			stop_with_failure("value mismatch");
		end
	endtask

	// ************************************************************
	// stimulus
	// ************************************************************

	// first pass covers every pixel once and later ones hit random pixels
	task automatic acc_pass(input bit first);
		int         order [NUM_PIXELS];
		int         addr;
		int         prev_addr;
		int         j;
		int         tmp;
		fmap_word_t word;
		for (int i = 0; i < NUM_PIXELS; i++)
			order[i] = i;
		for (int i = NUM_PIXELS - 1; i > 0; i--)
		begin
			j        = $urandom % (i + 1);
			tmp      = order[i];
			order[i] = order[j];
			order[j] = tmp;
		end
		prev_addr = -1;
		for (int i = 0; i < NUM_PIXELS; i++)
		begin
			if (first)
				addr = order[i];
			else if (prev_addr >= 0 && $urandom % 4 == 0)
				addr = prev_addr;
			else
				addr = $urandom % NUM_PIXELS;
			@(posedge clk);
			acc_valid   <= 1'b1;
			acc_first   <= first;
			acc_address <= fmap_addr_t'(addr);
			for (int u = 0; u < `NUM_UNITS; u++)
			begin
				word        = fmap_word_t'($urandom);
				acc_data[u] <= word;
				if (first)
					model_mem[model_sel][u][addr] = word;
				else
					model_mem[model_sel][u][addr] = model_mem[model_sel][u][addr] + word;
			end
			prev_addr = addr;
			// occasional idle cycle
			if (!first && $urandom % 8 == 0)
			begin
				@(posedge clk);
				acc_valid <= 1'b0;
			end
		end
	endtask

	task automatic acc_run(input int passes);
		for (int p = 0; p < passes; p++)
			acc_pass(p == 0);
		@(posedge clk);
		acc_valid <= 1'b0;
		acc_first <= 1'b0;
		repeat (2) @(posedge clk);
	endtask

	task automatic swap_groups();
		@(posedge clk);
		swap <= 1'b1;
		@(posedge clk);
		swap <= 1'b0;
		model_sel = (model_sel + 1) % `NUM_GROUPS;
	endtask

	// pools the group finished before the last swap
	task automatic pool_pass();
		fmap_word_t expected [NUM_PAIRS][`NUM_UNITS];
		fmap_word_t even_px;
		fmap_word_t odd_px;
		int         cons;
		int         k;
		int         waited;
		cons = (model_sel + 2) % `NUM_GROUPS;
		for (int p = 0; p < NUM_PAIRS; p++)
		begin
			for (int u = 0; u < `NUM_UNITS; u++)
			begin
				even_px        = model_mem[cons][u][2*p];
				odd_px         = model_mem[cons][u][2*p+1];
				expected[p][u] = (even_px > odd_px) ? even_px : odd_px;
			end
		end
		@(posedge clk);
		pool_start <= 1'b1;
		@(posedge clk);
		pool_start <= 1'b0;
		@(negedge clk);
		check_value("pool_busy", 1, pool_busy);
		k      = 0;
		waited = 0;
		while (k < NUM_PAIRS)
		begin
			if (pool_valid)
			begin
				if (k == 0)
					check_value("pool latency", 2, waited);
				for (int u = 0; u < `NUM_UNITS; u++)
					check_value($sformatf("pool_data[%0d] pair %0d", u, k), expected[k][u],
						pool_data[u]);
				check_value("pool_done", k == NUM_PAIRS - 1, pool_done);
				k++;
			end
			else if (k > 0)
				check_value("pool_valid", 1, pool_valid);
			else
			begin
				check_value("pool_done", 0, pool_done);
				waited++;
				if (waited > 8)
					stop_with_failure("pool results did not start in time");
			end
			@(negedge clk);
		end
		check_value("pool_busy", 0, pool_busy);
		check_value("pool_valid", 0, pool_valid);
		check_value("pool_done", 0, pool_done);
	endtask

	// ************************************************************
	// test sequence
	// ************************************************************

	initial
	begin
		reset       = 1'b1;
		swap        = 1'b0;
		acc_valid   = 1'b0;
		acc_first   = 1'b0;
		acc_address = '0;
		pool_start  = 1'b0;
		for (int u = 0; u < `NUM_UNITS; u++)
			acc_data[u] = '0;
		model_sel   = 0;
		void'($urandom(51));

		repeat (4) @(posedge clk);
		reset <= 1'b0;
		// outputs stay quiet until the first start
		repeat (4)
		begin
			@(negedge clk);
			check_value("pool_valid", 0, pool_valid);
			check_value("pool_done", 0, pool_done);
			check_value("pool_busy", 0, pool_busy);
		end

		// group 0 filled first and then pooled while the next group fills
		for (int r = 0; r < NUM_ROUNDS; r++)
		begin
			if (r == 0)
				acc_run(1 + $urandom % MAX_PASSES);
			else
			begin
				fork
					pool_pass();
					acc_run(1 + $urandom % MAX_PASSES);
				join
			end
			swap_groups();
		end
		pool_pass();

		$display("Finished with no errors");
		$finish;
	end

endmodule

// ==== hw/layer_pipeline_top.sv ====
`include "fmap_consts.svh"

module layer_pipeline_top (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 swap,
	input  logic                 acc_valid,
	input  logic                 acc_first,
	input  fmap_pkg::fmap_addr_t acc_address,
	input  fmap_pkg::fmap_word_t acc_data [`NUM_UNITS],
	input  logic                 pool_start,
	output logic                 pool_valid,
	output logic                 pool_done,
	output logic                 pool_busy,
	output fmap_pkg::fmap_word_t pool_data [`NUM_UNITS]
);

	import fmap_pkg::*;

	// accumulate to buffer
	logic       wr_en;
	logic       rd_prev_en;
	fmap_addr_t wr_address;
	fmap_addr_t rd_prev_address;
	fmap_word_t wr_data      [`NUM_UNITS];
	fmap_word_t rd_prev_data [`NUM_UNITS];

	// buffer to pool
	logic       rd_next_a_en;
	logic       rd_next_b_en;
	fmap_addr_t rd_next_a_address;
	fmap_addr_t rd_next_b_address;
	fmap_word_t rd_next_a_data [`NUM_UNITS];
	fmap_word_t rd_next_b_data [`NUM_UNITS];

	psum_accumulate_stage i_psum_accumulate_stage (
		.clk             (clk),
		.reset           (reset),
		.acc_valid       (acc_valid),
		.acc_first       (acc_first),
		.acc_address     (acc_address),
		.acc_data        (acc_data),
		.rd_prev_data    (rd_prev_data),
		.wr_en           (wr_en),
		.rd_prev_en      (rd_prev_en),
		.wr_address      (wr_address),
		.rd_prev_address (rd_prev_address),
		.wr_data         (wr_data)
	);

	fmap_buffer_array i_fmap_buffer_array (
		.clk               (clk),
		.reset             (reset),
		.swap              (swap),
		.wr_en             (wr_en),
		.rd_prev_en        (rd_prev_en),
		.wr_address        (wr_address),
		.rd_prev_address   (rd_prev_address),
		.wr_data           (wr_data),
		.rd_prev_data      (rd_prev_data),
		.rd_next_a_en      (rd_next_a_en),
		.rd_next_b_en      (rd_next_b_en),
		.rd_next_a_address (rd_next_a_address),
		.rd_next_b_address (rd_next_b_address),
		.rd_next_a_data    (rd_next_a_data),
		.rd_next_b_data    (rd_next_b_data)
	);

	pair_pool_stage i_pair_pool_stage (
		.clk               (clk),
		.reset             (reset),
		.pool_start        (pool_start),
		.rd_next_a_en      (rd_next_a_en),
		.rd_next_b_en      (rd_next_b_en),
		.rd_next_a_address (rd_next_a_address),
		.rd_next_b_address (rd_next_b_address),
		.rd_next_a_data    (rd_next_a_data),
		.rd_next_b_data    (rd_next_b_data),
		.pool_valid        (pool_valid),
		.pool_done         (pool_done),
		.pool_busy         (pool_busy),
		.pool_data         (pool_data)
	);

endmodule

// ==== hw/pair_pool_stage.sv ====
`include "fmap_consts.svh"

module pair_pool_stage (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 pool_start,
	// buffer side, even pixel on a and odd pixel on b
	output logic                 rd_next_a_en,
	output logic                 rd_next_b_en,
	output fmap_pkg::fmap_addr_t rd_next_a_address,
	output fmap_pkg::fmap_addr_t rd_next_b_address,
	input  fmap_pkg::fmap_word_t rd_next_a_data [`NUM_UNITS],
	input  fmap_pkg::fmap_word_t rd_next_b_data [`NUM_UNITS],
	// pooled results
	output logic                 pool_valid,
	output logic                 pool_done,
	output logic                 pool_busy,
	output fmap_pkg::fmap_word_t pool_data [`NUM_UNITS]
);

	import fmap_pkg::*;

	localparam int NUM_PAIRS  = (`FMAP_SIZE*`FMAP_SIZE)/2;
	localparam int PAIR_WIDTH = $bits(fmap_addr_t) - 1;

	logic                  busy;
	logic [PAIR_WIDTH-1:0] pair_cnt;
	logic                  last_pair;

	// flags tracking the RAM read latency
	logic                  rd_valid_q;
	logic                  rd_last_q;

	// ************************************************************
	// address scanner
	// ************************************************************

	assign last_pair = (pair_cnt == PAIR_WIDTH'(NUM_PAIRS-1));

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			busy     <= 1'b0;
			pair_cnt <= '0;
		end
		else if (!busy)
		begin
			if (pool_start)
			begin
				busy     <= 1'b1;
				pair_cnt <= '0;
			end
		end
		else
		begin
			pair_cnt <= pair_cnt + 1'b1;
			if (last_pair)
				busy <= 1'b0;
		end
	end

	assign pool_busy         = busy;
	assign rd_next_a_en      = busy;
	assign rd_next_b_en      = busy;
	assign rd_next_a_address = {pair_cnt, 1'b0};
	assign rd_next_b_address = {pair_cnt, 1'b1};

	// ************************************************************
	// signed maximum per unit
	// ************************************************************

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			rd_valid_q <= 1'b0;
			rd_last_q  <= 1'b0;
			pool_valid <= 1'b0;
			pool_done  <= 1'b0;
		end
		else
		begin
			rd_valid_q <= busy;
			rd_last_q  <= busy && last_pair;
			pool_valid <= rd_valid_q;
			pool_done  <= rd_last_q;
		end
	end

	always_ff @(posedge clk)
	begin
		for (int u = 0; u < `NUM_UNITS; u++)
		begin
			if (rd_next_a_data[u] > rd_next_b_data[u])
				pool_data[u] <= rd_next_a_data[u];
			else
				pool_data[u] <= rd_next_b_data[u];
		end
	end

endmodule

// ==== hw/psum_accumulate_stage.sv ====
`include "fmap_consts.svh"

module psum_accumulate_stage (
	input  logic                 clk,
	input  logic                 reset,
	// products from the convolution datapath
	input  logic                 acc_valid,
	input  logic                 acc_first,
	input  fmap_pkg::fmap_addr_t acc_address,
	input  fmap_pkg::fmap_word_t acc_data [`NUM_UNITS],
	// buffer side
	input  fmap_pkg::fmap_word_t rd_prev_data [`NUM_UNITS],
	output logic                 wr_en,
	output logic                 rd_prev_en,
	output fmap_pkg::fmap_addr_t wr_address,
	output fmap_pkg::fmap_addr_t rd_prev_address,
	output fmap_pkg::fmap_word_t wr_data [`NUM_UNITS]
);

	import fmap_pkg::*;

	// input held one cycle while the old value is read
	logic       valid_q;
	logic       first_q;
	fmap_addr_t addr_q;
	fmap_word_t data_q [`NUM_UNITS];

	// last write, for back-to-back hits on one address
	logic       wr_valid_q;
	fmap_addr_t wr_addr_q;
	fmap_word_t wr_data_q [`NUM_UNITS];

	logic       fwd_hit;
	fmap_word_t old_data [`NUM_UNITS];

	// read of the old partial sum goes out with the input
	assign rd_prev_en      = acc_valid;
	assign rd_prev_address = acc_address;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			valid_q    <= 1'b0;
			wr_valid_q <= 1'b0;
		end
		else
		begin
			valid_q    <= acc_valid;
			wr_valid_q <= wr_en;
		end
	end

	always_ff @(posedge clk)
	begin
		first_q   <= acc_first;
		addr_q    <= acc_address;
		wr_addr_q <= wr_address;
		for (int u = 0; u < `NUM_UNITS; u++)
		begin
			data_q[u]    <= acc_data[u];
			wr_data_q[u] <= wr_data[u];
		end
	end

	// ************************************************************
	// add or replace, then write one cycle after the input
	// ************************************************************

	// RAM still returns the value from before that write
	assign fwd_hit = wr_valid_q && (wr_addr_q == addr_q);

	always_comb
	begin
		for (int u = 0; u < `NUM_UNITS; u++)
		begin
			if (fwd_hit)
				old_data[u] = wr_data_q[u];
			else
				old_data[u] = rd_prev_data[u];

			// wraps at word width
			if (first_q)
				wr_data[u] = data_q[u];
			else
				wr_data[u] = old_data[u] + data_q[u];
		end
	end

	assign wr_en      = valid_q;
	assign wr_address = addr_q;

endmodule

// ==== hw/fmap_buffer_array.sv ====
`include "fmap_consts.svh"

module fmap_buffer_array (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 swap,
	// producer side, steered to group sel
	input  logic                 wr_en,
	input  logic                 rd_prev_en,
	input  fmap_pkg::fmap_addr_t wr_address,
	input  fmap_pkg::fmap_addr_t rd_prev_address,
	input  fmap_pkg::fmap_word_t wr_data [`NUM_UNITS],
	output fmap_pkg::fmap_word_t rd_prev_data [`NUM_UNITS],
	// consumer side, steered to the group finished before the last swap
	input  logic                 rd_next_a_en,
	input  logic                 rd_next_b_en,
	input  fmap_pkg::fmap_addr_t rd_next_a_address,
	input  fmap_pkg::fmap_addr_t rd_next_b_address,
	output fmap_pkg::fmap_word_t rd_next_a_data [`NUM_UNITS],
	output fmap_pkg::fmap_word_t rd_next_b_data [`NUM_UNITS]
);

	import fmap_pkg::*;

	group_sel_t sel;
	group_sel_t cons_sel;

	logic       a_en   [`NUM_GROUPS];
	logic       a_we   [`NUM_GROUPS];
	logic       b_en   [`NUM_GROUPS];
	fmap_addr_t a_addr [`NUM_GROUPS];
	fmap_addr_t b_addr [`NUM_GROUPS];

	fmap_word_t dout_a [`NUM_GROUPS][`NUM_UNITS];
	fmap_word_t dout_b [`NUM_GROUPS][`NUM_UNITS];

	// ************************************************************
	// group rotation
	// ************************************************************

	always_ff @(posedge clk)
	begin
		if (reset)
			sel <= '0;
		else if (swap)
		begin
			if (sel == group_sel_t'(`NUM_GROUPS-1))
				sel <= '0;
			else
				sel <= sel + 1'b1;
		end
	end

	// (sel+2) mod 3, i.e. one group behind the producer
	always_comb
	begin
		if (sel == '0)
			cons_sel = group_sel_t'(`NUM_GROUPS-1);
		else
			cons_sel = sel - 1'b1;
	end

	// ************************************************************
	// port steering
	// ************************************************************

	always_comb
	begin
		for (int g = 0; g < `NUM_GROUPS; g++)
		begin
			a_en[g]   = 1'b0;
			a_we[g]   = 1'b0;
			b_en[g]   = 1'b0;
			a_addr[g] = '0;
			b_addr[g] = '0;
			if (sel == group_sel_t'(g))
			begin
				// write on a, old partial sum read on b
				a_en[g]   = wr_en;
				a_we[g]   = wr_en;
				a_addr[g] = wr_address;
				b_en[g]   = rd_prev_en;
				b_addr[g] = rd_prev_address;
			end
			else if (cons_sel == group_sel_t'(g))
			begin
				a_en[g]   = rd_next_a_en;
				a_addr[g] = rd_next_a_address;
				b_en[g]   = rd_next_b_en;
				b_addr[g] = rd_next_b_address;
			end
		end
	end

	// ************************************************************
	// bank groups
	// ************************************************************

	for (genvar g = 0; g < `NUM_GROUPS; g++)
	begin : g_group
		for (genvar u = 0; u < `NUM_UNITS; u++)
		begin : g_unit
			dual_port_ram #(
				.DATA_WIDTH (`DATA_WIDTH),
				.DEPTH      (`FMAP_SIZE*`FMAP_SIZE)
			) i_dual_port_ram (
				.clk    (clk),
				.en_a   (a_en[g]),
				.we_a   (a_we[g]),
				.en_b   (b_en[g]),
				.we_b   (1'b0),
				.addr_a (a_addr[g]),
				.addr_b (b_addr[g]),
				.din_a  (wr_data[u]),
				.din_b  ('0),
				.dout_a (dout_a[g][u]),
				.dout_b (dout_b[g][u])
			);
		end
	end

	// output select, sel stays put while either side is active
	always_comb
	begin
		for (int u = 0; u < `NUM_UNITS; u++)
		begin
			rd_prev_data[u]   = dout_b[sel][u];
			rd_next_a_data[u] = dout_a[cons_sel][u];
			rd_next_b_data[u] = dout_b[cons_sel][u];
		end
	end

endmodule

// ==== hw/dual_port_ram.sv ====
`include "fmap_consts.svh"

module dual_port_ram #(
	parameter int DATA_WIDTH = `DATA_WIDTH,
	parameter int DEPTH      = `FMAP_SIZE*`FMAP_SIZE
) (
	input  logic                     clk,
	input  logic                     en_a,
	input  logic                     we_a,
	input  logic                     en_b,
	input  logic                     we_b,
	input  logic [$clog2(DEPTH)-1:0] addr_a,
	input  logic [$clog2(DEPTH)-1:0] addr_b,
	input  logic [DATA_WIDTH-1:0]    din_a,
	input  logic [DATA_WIDTH-1:0]    din_b,
	output logic [DATA_WIDTH-1:0]    dout_a,
	output logic [DATA_WIDTH-1:0]    dout_b
);

	logic [DATA_WIDTH-1:0] mem [DEPTH];

	// port a, read output held while disabled or writing
	always_ff @(posedge clk)
	begin
		if (en_a)
		begin
			if (we_a)
				mem[addr_a] <= din_a;
			else
				dout_a <= mem[addr_a];
		end
	end

	// port b
	always_ff @(posedge clk)
	begin
		if (en_b)
		begin
			if (we_b)
				mem[addr_b] <= din_b;
			else
				dout_b <= mem[addr_b];
		end
	end

endmodule

// ==== hw/fmap_pkg.sv ====
`include "fmap_consts.svh"

package fmap_pkg;

	// ************************************************************
	// shared feature-map types
	// ************************************************************

	// one signed feature-map word
	typedef logic signed [`DATA_WIDTH-1:0] fmap_word_t;

	// pixel address inside one map
	typedef logic [$clog2(`FMAP_SIZE*`FMAP_SIZE)-1:0] fmap_addr_t;

	// bank group index, 0 to NUM_GROUPS-1 only
	typedef logic [$clog2(`NUM_GROUPS)-1:0] group_sel_t;

endpackage

// ==== hw/fmap_consts.svh ====
`ifndef FMAP_CONSTS_SVH
`define FMAP_CONSTS_SVH

// feature-map word width in bits
`define DATA_WIDTH 16

// side of the square map, FMAP_SIZE*FMAP_SIZE pixels per RAM
`define FMAP_SIZE 8

// parallel channels, one RAM per unit in each group
`define NUM_UNITS 4

// bank groups rotating between producer, consumer and idle
`define NUM_GROUPS 3

`endif
